//--- src/controlUnit_macros.svh
`ifndef CONTROLUNIT_MACROS_SVH
`define CONTROLUNIT_MACROS_SVH

// Instruction fields
`define OPCODE_FIELD 31:26
`define RS_FIELD 25:21
`define RT_FIELD 20:16
`define RD_FIELD 15:11
`define IMM_FIELD 15:0
`define TARGET_FIELD 25:0
`define FUNC_FIELD 5:0

`define OP_RTYPE 6'b000000
`define OP_ADDI 6'b001000
`define OP_ADDIU 6'b001001
`define OP_SLTI 6'b001010
`define OP_SLTIU 6'b001011
`define OP_ANDI 6'b001100
`define OP_ORI 6'b001101
`define OP_XORI 6'b001110
`define OP_LUI 6'b001111
`define OP_LW 6'b100011
`define OP_SW 6'b101011
`define OP_BEQ 6'b000100
`define OP_BNE 6'b000101
`define OP_J 6'b000010

// Function codes under OP_RTYPE
`define FN_ADD 6'b100000
`define FN_ADDU 6'b100001
`define FN_SUB 6'b100010
`define FN_SUBU 6'b100011
`define FN_AND 6'b100100
`define FN_OR 6'b100101
`define FN_XOR 6'b100110
`define FN_NOR 6'b100111
`define FN_SLT 6'b101010
`define FN_SLTU 6'b101011

`define ALU_PASS 4'b0000
`define ALU_ADD 4'b0001
`define ALU_AND 4'b0100
`define ALU_OR 4'b0101
`define ALU_NOR 4'b0110
`define ALU_LUI 4'b1010
`define ALU_PC4 4'b1011 // PC plus four
`define ALU_XOR 4'b1100
`define ALU_CMP 4'b1101

// Compare selects for ALU_CMP
`define CMP_SLT 4'b0000
`define CMP_SLTU 4'b0001
`define CMP_SLTI 4'b0010
`define CMP_SLTIU 4'b0011
`define CMP_EQ 4'b1000
`define CMP_NE 4'b1100

`define SIGN_ADDU 2'b00 // Bit 1 signed, bit 0 subtract
`define SIGN_SUBU 2'b01
`define SIGN_ADD 2'b10
`define SIGN_SUB 2'b11

`define EXT_ZERO 2'b00
`define EXT_SIGN 2'b01

`define PC_ADDR_BITS 9 // Branch target bits kept

`endif

//--- src/controlPkg.sv
package controlPkg;

	typedef logic [31:0] wordT; // Instruction or PC word
	typedef logic [5:0] opcodeT;
	typedef logic [5:0] funcT;
	typedef logic [4:0] regAddrT;
	typedef logic [3:0] aluOpT;
	typedef logic [1:0] aluSignT;
	typedef logic [3:0] cmpSelT;
	typedef logic [1:0] extT; // Immediate extension mode

	// Execute path chosen in decode
	typedef enum logic [3:0] {
		aluReg,
		aluRegTrap, // add, sub
		aluImm,
		aluImmTrap, // addi
		load,
		store,
		branchEq,
		branchNe,
		jump,
		invalid
	} instrClassT;

	typedef enum logic [3:0] {
		resetS,
		fetchAddr, // PC into MAR
		fetchRead,
		fetchWait,
		fetchLoad, // Memory word into IR
		decodeS,
		executeS,
		overflowCheck,
		memAddr,
		storeData,
		memWait,
		loadData,
		loadWrite,
		branchS,
		jumpS
	} cuStateT;

endpackage

//--- src/instrDecoder.sv
`timescale 1ns/1ns
`include "controlUnit_macros.svh"

module instrDecoder (
	input controlPkg::wordT instruction,
	output controlPkg::instrClassT instrClass,
	output controlPkg::aluOpT decAluOp,
	output controlPkg::aluSignT decAluSign,
	output controlPkg::cmpSelT decCmpSel,
	output controlPkg::extT decSignExt,
	output logic decUseImm,
	output controlPkg::regAddrT regFileRS,
	output controlPkg::regAddrT regFileRT,
	output controlPkg::regAddrT regFileRD
);
	import controlPkg::*;

	opcodeT opcode;
	funcT funcCode;

	assign opcode = instruction[`OPCODE_FIELD];
	assign funcCode = instruction[`FUNC_FIELD];

	assign regFileRS = instruction[`RS_FIELD];
	assign regFileRT = instruction[`RT_FIELD];
	// Register forms write rd, everything else rt
	assign regFileRD = (opcode == `OP_RTYPE) ? instruction[`RD_FIELD] : instruction[`RT_FIELD];

	always_comb begin
		instrClass = invalid;
		decAluOp = `ALU_PASS;
		decAluSign = `SIGN_ADDU;
		decCmpSel = `CMP_SLT;
		decSignExt = `EXT_ZERO;
		decUseImm = 1'b1; // Cleared for register operands below
		case (opcode)
			`OP_RTYPE: begin
				instrClass = aluReg;
				decUseImm = 1'b0;
				case (funcCode)
					`FN_ADDU: decAluOp = `ALU_ADD;
					`FN_ADD: begin
						instrClass = aluRegTrap;
						decAluOp = `ALU_ADD;
						decAluSign = `SIGN_ADD;
					end
					`FN_SUBU: begin
						decAluOp = `ALU_ADD;
						decAluSign = `SIGN_SUBU;
					end
					`FN_SUB: begin
						instrClass = aluRegTrap;
						decAluOp = `ALU_ADD;
						decAluSign = `SIGN_SUB;
					end
					`FN_AND: decAluOp = `ALU_AND;
					`FN_OR: decAluOp = `ALU_OR;
					`FN_XOR: decAluOp = `ALU_XOR;
					`FN_NOR: decAluOp = `ALU_NOR;
					`FN_SLT: decAluOp = `ALU_CMP;
					`FN_SLTU: begin
						decAluOp = `ALU_CMP;
						decCmpSel = `CMP_SLTU;
					end
					default: instrClass = invalid; // Unknown function code
				endcase
			end
			`OP_ADDI: begin
				instrClass = aluImmTrap;
				decAluOp = `ALU_ADD;
				decAluSign = `SIGN_ADD;
				decSignExt = `EXT_SIGN;
			end
			`OP_ADDIU: begin
				instrClass = aluImm;
				decAluOp = `ALU_ADD;
				decAluSign = `SIGN_ADD;
				decSignExt = `EXT_SIGN;
			end
			`OP_ANDI: begin
				instrClass = aluImm;
				decAluOp = `ALU_AND;
			end
			`OP_ORI: begin
				instrClass = aluImm;
				decAluOp = `ALU_OR;
			end
			`OP_XORI: begin
				instrClass = aluImm;
				decAluOp = `ALU_XOR;
			end
			`OP_LUI: begin
				instrClass = aluImm;
				decAluOp = `ALU_LUI;
			end
			`OP_SLTI, `OP_SLTIU: begin
				instrClass = aluImm;
				decAluOp = `ALU_CMP;
				decCmpSel = (opcode == `OP_SLTI) ? `CMP_SLTI : `CMP_SLTIU;
				decSignExt = `EXT_SIGN;
			end
			`OP_LW, `OP_SW: begin
				instrClass = (opcode == `OP_LW) ? load : store;
				decAluOp = `ALU_ADD; // Base plus offset
				decSignExt = `EXT_SIGN;
			end
			`OP_BEQ, `OP_BNE: begin
				instrClass = (opcode == `OP_BEQ) ? branchEq : branchNe;
				decAluOp = `ALU_CMP;
				decCmpSel = (opcode == `OP_BEQ) ? `CMP_EQ : `CMP_NE;
				decUseImm = 1'b0;
			end
			`OP_J: instrClass = jump;
			default: instrClass = invalid;
		endcase
	end

endmodule

//--- src/pcRedirect.sv
`timescale 1ns/1ns
`include "controlUnit_macros.svh"

module pcRedirect (
	input logic Clk,
	input logic rstN,
	input controlPkg::wordT instruction,
	input controlPkg::wordT currentPC,
	input logic branchTaken,
	input logic jumpTaken,
	input logic fetchIssue,
	output controlPkg::wordT nextPC,
	output logic muxSignals5
);
	import controlPkg::*;

	wordT branchOffset;
	wordT branchTarget;
	wordT jumpTarget;
	logic pending; // Target waits for the next fetch

	assign branchOffset = {{14{instruction[15]}}, instruction[`IMM_FIELD], 2'b00};

	always_comb begin
		branchTarget = currentPC + branchOffset;
		branchTarget[31:`PC_ADDR_BITS] = '0; // Small program memory
	end

	assign jumpTarget = {currentPC[31:28], instruction[`TARGET_FIELD], 2'b00};

	always_ff @(posedge Clk) begin
		if (branchTaken)
			nextPC <= branchTarget;
		else if (jumpTaken)
			nextPC <= jumpTarget;
	end

	always_ff @(posedge Clk or negedge rstN) begin
		if (!rstN)
			pending <= 1'b0;
		else if (branchTaken || jumpTaken)
			pending <= 1'b1;
		else if (fetchIssue)
			pending <= 1'b0; // Consumed by this fetch
	end

	assign muxSignals5 = pending && fetchIssue;

	assert property (@(posedge Clk) disable iff (!rstN) !(branchTaken && jumpTaken));

endmodule

//--- src/controlSequencer.sv
`timescale 1ns/1ns
`include "controlUnit_macros.svh"

module controlSequencer (
	input logic Clk,
	input logic rstN,
	input controlPkg::instrClassT instrClass,
	input controlPkg::aluOpT decAluOp,
	input controlPkg::aluSignT decAluSign,
	input controlPkg::cmpSelT decCmpSel,
	input controlPkg::extT decSignExt,
	input logic decUseImm,
	input logic [3:0] aluCarryFlags,
	input logic ramMFC,
	output logic clearPC,
	output logic pcEnable,
	output logic irEnable,
	output logic marEnable,
	output logic mdrEnable,
	output logic regFileRW,
	output logic ramMFA,
	output logic ramRW,
	output logic trapMux,
	output logic [1:0] muxSignals,
	output logic muxSignals2,
	output controlPkg::aluOpT aluOperation,
	output controlPkg::aluSignT aluSign,
	output controlPkg::cmpSelT cmpsignal,
	output controlPkg::extT signExtend,
	output logic branchTaken,
	output logic jumpTaken,
	output logic fetchIssue
);
	import controlPkg::*;

	cuStateT state;
	cuStateT nextState;
	logic isTrapClass;
	logic flag; // Overflow or compare result

	assign isTrapClass = (instrClass == aluRegTrap) || (instrClass == aluImmTrap);
	assign flag = aluCarryFlags[0];

	always_ff @(posedge Clk or negedge rstN) begin
		if (!rstN)
			state <= resetS;
		else
			state <= nextState;
	end

	always_comb begin
		nextState = state;
		case (state)
			resetS: nextState = fetchAddr;
			fetchAddr: nextState = fetchRead;
			fetchRead: nextState = fetchWait;
			fetchWait: if (ramMFC) nextState = fetchLoad;
			fetchLoad: nextState = decodeS;
			decodeS: begin
				case (instrClass)
					aluReg, aluRegTrap, aluImm, aluImmTrap: nextState = executeS;
					load, store: nextState = memAddr;
					branchEq, branchNe: nextState = branchS;
					jump: nextState = jumpS;
					default: nextState = fetchAddr; // Invalid code
				endcase
			end
			executeS: nextState = isTrapClass ? overflowCheck : fetchAddr;
			overflowCheck: nextState = flag ? fetchWait : fetchAddr; // Trap vector fetch
			memAddr: nextState = (instrClass == store) ? storeData : memWait;
			storeData: nextState = memWait;
			memWait: begin
				if (ramMFC)
					nextState = (instrClass == load) ? loadData : fetchAddr;
			end
			loadData: nextState = loadWrite;
			loadWrite, branchS, jumpS: nextState = fetchAddr;
			default: nextState = resetS;
		endcase
	end

	always_comb begin
		clearPC = 1'b0;
		pcEnable = 1'b0;
		irEnable = 1'b0;
		marEnable = 1'b0;
		mdrEnable = 1'b0;
		regFileRW = 1'b0;
		ramMFA = 1'b0;
		ramRW = 1'b0;
		trapMux = 1'b0;
		muxSignals = 2'b00;
		muxSignals2 = 1'b0;
		aluOperation = `ALU_PASS;
		aluSign = `SIGN_ADDU;
		cmpsignal = `CMP_SLT;
		signExtend = `EXT_ZERO;
		branchTaken = 1'b0;
		jumpTaken = 1'b0;
		fetchIssue = 1'b0;
		// ALU controls from decode
		if (state inside {executeS, overflowCheck, memAddr, branchS}) begin
			aluOperation = decAluOp;
			aluSign = decAluSign;
			cmpsignal = decCmpSel;
			signExtend = decSignExt;
			muxSignals = decUseImm ? 2'b01 : 2'b00;
		end
		case (state)
			resetS: clearPC = 1'b1;
			fetchAddr: begin
				marEnable = 1'b1;
				muxSignals = 2'b11;
			end
			fetchRead: begin
				pcEnable = 1'b1;
				ramMFA = 1'b1;
				aluOperation = `ALU_PC4;
				muxSignals = 2'b11;
				fetchIssue = 1'b1;
			end
			fetchWait: ramMFA = 1'b1;
			fetchLoad: irEnable = 1'b1;
			executeS: regFileRW = !isTrapClass; // Trap forms write after the check
			overflowCheck: begin
				trapMux = flag;
				ramMFA = flag;
				regFileRW = !flag;
			end
			memAddr: marEnable = 1'b1;
			storeData: mdrEnable = 1'b1; // Register rt into MDR
			memWait: begin
				ramMFA = 1'b1;
				ramRW = (instrClass == store);
			end
			loadData: begin
				mdrEnable = 1'b1;
				muxSignals2 = 1'b1;
			end
			loadWrite: begin
				regFileRW = 1'b1;
				muxSignals = 2'b10;
				muxSignals2 = 1'b1;
			end
			branchS: branchTaken = flag;
			jumpS: jumpTaken = 1'b1;
			default: ;
		endcase
	end

	// A fetch never overlaps a register write
	assert property (@(posedge Clk) disable iff (!rstN) !(pcEnable && regFileRW));

	assert property (@(posedge Clk) disable iff (!rstN) $rose(ramMFA) |-> !marEnable);

	// Memory request held until acknowledged
	assert property (@(posedge Clk) disable iff (!rstN) ramMFA && !ramMFC |=> ramMFA);

endmodule

//--- src/controlUnit.sv
`timescale 1ns/1ns

module controlUnit (
	output controlPkg::wordT nextPC,
	output logic muxSignals5,
	output controlPkg::cmpSelT cmpsignal,
	output logic trapMux,
	output controlPkg::extT signExtend,
	output logic clearPC,
	output logic regFileRW,
	output controlPkg::regAddrT regFileRD,
	output controlPkg::regAddrT regFileRS,
	output controlPkg::regAddrT regFileRT,
	output controlPkg::aluSignT aluSign,
	output controlPkg::aluOpT aluOperation,
	output logic ramMFA,
	output logic ramRW,
	output logic pcEnable,
	output logic irEnable,
	output logic marEnable,
	output logic mdrEnable,
	output logic [1:0] muxSignals, // ALU B operand select
	output logic muxSignals2, // MDR source select
	input controlPkg::wordT instruction,
	input logic [3:0] aluCarryFlags,
	input logic ramMFC,
	input logic Clk,
	input logic rstN,
	input controlPkg::wordT currentPC
);
	import controlPkg::*;

	instrClassT instrClass;
	aluOpT decAluOp;
	aluSignT decAluSign;
	cmpSelT decCmpSel;
	extT decSignExt;
	logic decUseImm;
	logic branchTaken;
	logic jumpTaken;
	logic fetchIssue;

	instrDecoder i_instrDecoder (
		.instruction(instruction), .instrClass(instrClass),
		.decAluOp(decAluOp), .decAluSign(decAluSign), .decCmpSel(decCmpSel),
		.decSignExt(decSignExt), .decUseImm(decUseImm),
		.regFileRS(regFileRS), .regFileRT(regFileRT), .regFileRD(regFileRD)
	);

	pcRedirect i_pcRedirect (
		.Clk(Clk), .rstN(rstN), .instruction(instruction), .currentPC(currentPC),
		.branchTaken(branchTaken), .jumpTaken(jumpTaken), .fetchIssue(fetchIssue),
		.nextPC(nextPC), .muxSignals5(muxSignals5)
	);

	controlSequencer i_controlSequencer (
		.Clk(Clk), .rstN(rstN), .instrClass(instrClass),
		.decAluOp(decAluOp), .decAluSign(decAluSign), .decCmpSel(decCmpSel),
		.decSignExt(decSignExt), .decUseImm(decUseImm),
		.aluCarryFlags(aluCarryFlags), .ramMFC(ramMFC),
		.clearPC(clearPC), .pcEnable(pcEnable), .irEnable(irEnable),
		.marEnable(marEnable), .mdrEnable(mdrEnable), .regFileRW(regFileRW),
		.ramMFA(ramMFA), .ramRW(ramRW), .trapMux(trapMux),
		.muxSignals(muxSignals), .muxSignals2(muxSignals2),
		.aluOperation(aluOperation), .aluSign(aluSign), .cmpsignal(cmpsignal),
		.signExtend(signExtend), .branchTaken(branchTaken), .jumpTaken(jumpTaken),
		.fetchIssue(fetchIssue)
	);

endmodule

//--- tb/controlRef.svh
`ifndef CONTROLREF_SVH
`define CONTROLREF_SVH

// Expected decode of one instruction
typedef struct packed {
	instrClassT cls;
	aluOpT aluOp;
	aluSignT sign;
	cmpSelT cmp;
	extT ext;
	logic [1:0] operandSel; // Expected muxSignals in the ALU cycle
	regAddrT dest;
	wordT target;
} expectT;

function automatic expectT expectedFor(input wordT instr, input wordT pc);
	expectT e;
	logic [5:0] op;
	logic [5:0] fn;
	wordT offset;
	op = instr[31:26];
	fn = instr[5:0];
	offset = instr[15] ? {16'hffff, instr[15:0]} : {16'h0000, instr[15:0]};
	e = '0; // Pass op, unsigned add, slt select, zero extension
	e.cls = invalid;
	e.operandSel = 2'b01;
	e.dest = instr[20:16];
	if (op == 6'b000000) begin
		e.operandSel = 2'b00;
		e.dest = instr[15:11];
		if (fn[5:2] == 4'b1000) begin // add, addu, sub, subu
			e.cls = fn[0] ? aluReg : aluRegTrap;
			e.aluOp = `ALU_ADD;
			e.sign = {!fn[0], fn[1]};
		end else if (fn[5:2] == 4'b1001) begin
			e.cls = aluReg;
			case (fn[1:0])
				2'b00: e.aluOp = `ALU_AND;
				2'b01: e.aluOp = `ALU_OR;
				2'b10: e.aluOp = `ALU_XOR;
				default: e.aluOp = `ALU_NOR;
			endcase
		end else if (fn[5:1] == 5'b10101) begin
			e.cls = aluReg;
			e.aluOp = `ALU_CMP;
			e.cmp = fn[0] ? `CMP_SLTU : `CMP_SLT;
		end
	end else if (op[5:3] == 3'b001) begin
		e.cls = aluImm;
		case (op[2:1])
			2'b00: begin
				if (!op[0])
					e.cls = aluImmTrap; // addi
				e.aluOp = `ALU_ADD;
				e.sign = `SIGN_ADD;
				e.ext = `EXT_SIGN;
			end
			2'b01: begin
				e.aluOp = `ALU_CMP;
				e.cmp = op[0] ? `CMP_SLTIU : `CMP_SLTI;
				e.ext = `EXT_SIGN;
			end
			2'b10: e.aluOp = op[0] ? `ALU_OR : `ALU_AND;
			default: e.aluOp = op[0] ? `ALU_LUI : `ALU_XOR;
		endcase
	end else if (op == `OP_LW || op == `OP_SW) begin
		e.cls = (op == `OP_LW) ? load : store;
		e.aluOp = `ALU_ADD;
		e.ext = `EXT_SIGN;
	end else if (op == `OP_BEQ || op == `OP_BNE) begin
		e.cls = op[0] ? branchNe : branchEq;
		e.aluOp = `ALU_CMP;
		e.cmp = op[0] ? `CMP_NE : `CMP_EQ;
		e.operandSel = 2'b00;
		e.target = (pc + 4 * offset) & ((32'd1 << `PC_ADDR_BITS) - 1);
	end else if (op == `OP_J) begin
		e.cls = jump;
		e.target = (pc & 32'hf000_0000) | ({6'd0, instr[25:0]} << 2);
	end
	return e;
endfunction

task automatic compareValue(input string what, input logic [31:0] got, input logic [31:0] want);
	checkCount++;
	if (got !== want) begin
		errorCount++;
		$display("ERROR at %0t ns: %s is %0h, expected %0h", $time, what, got, want);
	end
endtask

// xorshift32 step
function automatic logic [31:0] nextRandom(input logic [31:0] x);
	logic [31:0] y;
	y = x ^ (x << 13);
	y = y ^ (y >> 17);
	y = y ^ (y << 5);
	return y;
endfunction

`endif

//--- tb/controlUnitTb.sv
`timescale 1ns/1ns
`include "controlUnit_macros.svh"

module controlUnitTb;
	import controlPkg::*;

	localparam int clkPeriod = 100;
	localparam int resetCycles = 8;
	localparam int numInstr = 40;
	localparam int numKinds = 25;
	localparam int maxCyclesPerInstr = 12;

	// Bits of strobeVector()
	localparam logic [8:0] bClear = 9'h100;
	localparam logic [8:0] bPc = 9'h080;
	localparam logic [8:0] bIr = 9'h040;
	localparam logic [8:0] bMar = 9'h020;
	localparam logic [8:0] bMdr = 9'h010;
	localparam logic [8:0] bRegWr = 9'h008;
	localparam logic [8:0] bMfa = 9'h004;
	localparam logic [8:0] bRamWr = 9'h002;
	localparam logic [8:0] bTrap = 9'h001;

	// Opcode and function code per kind with kind 0 in the low bits
	localparam logic [numKinds*12-1:0] kindCodes = {
		{`OP_RTYPE, 6'b111111}, {6'b111111, 6'd0}, {`OP_J, 6'd0}, {`OP_SW, 6'd0},
		{`OP_LW, 6'd0}, {`OP_LUI, 6'd0}, {`OP_SLTIU, 6'd0}, {`OP_SLTI, 6'd0},
		{`OP_XORI, 6'd0}, {`OP_ORI, 6'd0}, {`OP_ANDI, 6'd0}, {`OP_ADDIU, 6'd0},
		{`OP_RTYPE, `FN_SLTU}, {`OP_RTYPE, `FN_SLT}, {`OP_RTYPE, `FN_NOR},
		{`OP_RTYPE, `FN_XOR}, {`OP_RTYPE, `FN_OR}, {`OP_RTYPE, `FN_AND},
		{`OP_RTYPE, `FN_SUBU}, {`OP_RTYPE, `FN_ADDU},
		{`OP_BNE, 6'd0}, {`OP_BEQ, 6'd0}, {`OP_ADDI, 6'd0},
		{`OP_RTYPE, `FN_SUB}, {`OP_RTYPE, `FN_ADD}
	};

	logic Clk = 1'b0;
	logic rstN;
	wordT instruction;
	wordT currentPC;
	logic [3:0] aluCarryFlags;
	logic ramMFC;
	wordT nextPC;
	logic muxSignals5;
	cmpSelT cmpsignal;
	extT signExtend;
	aluSignT aluSign;
	aluOpT aluOperation;
	regAddrT regFileRD, regFileRS, regFileRT;
	logic clearPC, regFileRW, trapMux, ramMFA, ramRW;
	logic pcEnable, irEnable, marEnable, mdrEnable;
	logic [1:0] muxSignals;
	logic muxSignals2;

	int errorCount = 0;
	int checkCount = 0;
	logic [31:0] rngState;
	int waitLeft; // Responder cycles left or negative when idle
	logic firstFlag [numKinds];

	`include "controlRef.svh"

	function automatic logic [8:0] strobeVector();
		return {clearPC, pcEnable, irEnable, marEnable, mdrEnable, regFileRW, ramMFA, ramRW,
			trapMux};
	endfunction

	task automatic checkAluControls(input expectT e);
		compareValue("aluOperation", aluOperation, e.aluOp);
		compareValue("aluSign", aluSign, e.sign);
		compareValue("cmpsignal", cmpsignal, e.cmp);
		compareValue("signExtend", signExtend, e.ext);
		compareValue("muxSignals", muxSignals, e.operandSel);
		compareValue("regFileRS", regFileRS, instruction[25:21]);
		compareValue("regFileRT", regFileRT, instruction[20:16]);
		compareValue("regFileRD", regFileRD, e.dest);
	endtask

	controlUnit i_controlUnit (.*);

	always #(clkPeriod / 2) Clk = ~Clk;

	// New instruction in every fetchLoad cycle
	initial begin
		int kind;
		logic flag;
		logic [5:0] op;
		logic [5:0] fn;
		rstN = 1'b0;
		instruction = '0;
		currentPC = '0;
		aluCarryFlags = '0;
		ramMFC = 1'b0;
		rngState = 32'd87;
		waitLeft = -1;
		repeat (resetCycles) @(posedge Clk);
		#5 rstN = 1'b1;
		for (int n = 0; n < numInstr; n++) begin
			do begin
				@(posedge Clk);
				#5;
			end while (!irEnable);
			kind = n % numKinds;
			{op, fn} = kindCodes[kind*12 +: 12];
			rngState = nextRandom(rngState);
			if (op == `OP_RTYPE)
				instruction = {op, rngState[25:11], 5'd0, fn};
			else
				instruction = {op, rngState[25:0]};
			rngState = nextRandom(rngState);
			currentPC = rngState;
			rngState = nextRandom(rngState);
			flag = (n < numKinds) ? rngState[0] : !firstFlag[kind]; // Second pass flips it
			firstFlag[kind] = flag;
			aluCarryFlags = {rngState[3:1], flag};
		end
	end

	// Memory answers 0 to 3 cycles after a request
	always begin
		@(posedge Clk);
		#5;
		if (!ramMFA) begin
			ramMFC = 1'b0;
			waitLeft = -1;
		end else begin
			if (waitLeft < 0) begin
				rngState = nextRandom(rngState);
				waitLeft = rngState[1:0];
			end
			if (waitLeft == 0)
				ramMFC = 1'b1;
			else
				waitLeft--;
		end
	end

	// Compare outputs at each falling edge
	initial begin
		expectT want;
		logic fullFetch;
		logic pending; // Redirect expected on the next fetch
		logic flag;
		logic done;
		logic trapping;
		logic [8:0] memStrobes;
		fullFetch = 1'b1;
		pending = 1'b0;
		@(negedge Clk);
		while (!rstN) begin
			compareValue("strobes in reset", strobeVector(), bClear);
			@(negedge Clk);
		end
		compareValue("strobes in resetS", strobeVector(), bClear);
		@(negedge Clk);
		for (int n = 0; n < numInstr; n++) begin
			if (fullFetch) begin
				compareValue("fetchAddr strobes", strobeVector(), bMar);
				compareValue("muxSignals5 in fetchAddr", muxSignals5, 1'b0);
				@(negedge Clk);
				compareValue("fetchRead strobes", strobeVector(), bPc | bMfa);
				compareValue("muxSignals5 in fetchRead", muxSignals5, pending);
				pending = 1'b0;
				@(negedge Clk);
			end
			do begin
				compareValue("fetchWait strobes", strobeVector(), bMfa);
				@(negedge Clk);
			end while (!irEnable);
			compareValue("fetchLoad strobes", strobeVector(), bIr);
			want = expectedFor(instruction, currentPC);
			flag = aluCarryFlags[0];
			trapping = (want.cls == aluRegTrap) || (want.cls == aluImmTrap);
			fullFetch = 1'b1;
			@(negedge Clk);
			compareValue("decode strobes", strobeVector(), 9'h000);
			compareValue("muxSignals5 in decode", muxSignals5, 1'b0);
			if (want.cls != invalid)
				@(negedge Clk);
			case (want.cls)
				aluReg, aluImm, aluRegTrap, aluImmTrap: begin
					checkAluControls(want);
					compareValue("execute strobes", strobeVector(), trapping ? 9'h000 : bRegWr);
					if (trapping) begin
						@(negedge Clk);
						compareValue("overflowCheck strobes", strobeVector(),
							flag ? (bTrap | bMfa) : bRegWr);
						fullFetch = !flag; // Trap vector fetch skips fetchAddr and fetchRead
					end
				end
				load, store: begin
					checkAluControls(want);
					compareValue("memAddr strobes", strobeVector(), bMar);
					if (want.cls == store) begin
						@(negedge Clk);
						compareValue("storeData strobes", strobeVector(), bMdr);
						compareValue("muxSignals2 on store", muxSignals2, 1'b0);
					end
					memStrobes = (want.cls == store) ? (bMfa | bRamWr) : bMfa;
					@(negedge Clk);
					do begin
						compareValue("memWait strobes", strobeVector(), memStrobes);
						done = ramMFC;
						if (!done)
							@(negedge Clk);
					end while (!done);
					if (want.cls == load) begin
						@(negedge Clk);
						compareValue("loadData strobes", strobeVector(), bMdr);
						compareValue("muxSignals2 on load", muxSignals2, 1'b1);
						@(negedge Clk);
						compareValue("loadWrite strobes", strobeVector(), bRegWr);
						compareValue("muxSignals on load write", muxSignals, 2'b10);
					end
				end
				branchEq, branchNe: begin
					checkAluControls(want);
					compareValue("branch strobes", strobeVector(), 9'h000);
					pending = flag;
				end
				jump: begin
					compareValue("jump strobes", strobeVector(), 9'h000);
					pending = 1'b1;
				end
				default: ; // Straight back to fetch
			endcase
			@(negedge Clk);
			if (pending)
				compareValue("nextPC", nextPC, want.target);
		end
		$display("Checks: %0d, errors: %0d", checkCount, errorCount);
		if (errorCount == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

	initial begin
		#(numInstr * maxCyclesPerInstr * clkPeriod + resetCycles * clkPeriod);
		$display("Timeout: the run did not get through %0d instructions in time", numInstr);
		$display("sim failed");
		$finish;
	end

endmodule

//--- sim.f
+incdir+src
+incdir+tb
src/controlPkg.sv
src/instrDecoder.sv
src/pcRedirect.sv
src/controlSequencer.sv
src/controlUnit.sv
tb/controlUnitTb.sv
